// ==== src.f ====
+incdir+include
verilog/cache_pkg.sv
verilog/cpu_port.sv
verilog/cache_direct.sv
verilog/mem_sequencer.sv
verilog/main_memory.sv
verilog/cache_top.sv
tb/tb_cache.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_cache -o tb_cache_sim
out=$(./obj_dir/tb_cache_sim)
echo "$out"

if echo "$out" | grep -q "Regression passed"; then
	exit 0
fi
exit 1

// ==== tb/tb_cache.sv ====
`timescale 1ns/1ps

`include "cache_consts.svh"

module tb_cache;
	import cache_pkg::*;

	localparam int MEM_BYTES = `MEM_LINES * (`LINE_WIDTH / 8);
	localparam int TIMEOUT = 200; // Cycles per handshake phase

	logic clk = 1'b0;
	logic reset;
	logic req;
	logic ack;
	addr_t addr;
	logic write_enable;
	logic byte_enable;
	word_t data_in;
	word_t data_out;

	// Byte-wide shadow of the backing memory
	logic [7:0] shadow [MEM_BYTES];
	bit written [MEM_BYTES];
	addr_t wr_list [$];

	integer seed = 55;
	int checks = 0;
	int errors = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic aborted = 1'b0;

	cache_top i_cache_top (
		.clk(clk), .reset(reset),
		.req(req), .ack(ack), .addr(addr), .write_enable(write_enable),
		.byte_enable(byte_enable), .data_in(data_in), .data_out(data_out)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////
	// Model
	////////////////////////////////////////
	task automatic write_shadow(input addr_t a, input logic be, input word_t d);
		int k;
		if (be) begin
			shadow[a[10:0]] = d[7:0];
			written[a[10:0]] = 1'b1;
		end else begin
			for (k = 0; k < 4; k++) begin
				shadow[{a[10:2], 2'(k)}] = d[k * 8 +: 8]; // Little endian within the word
				written[{a[10:2], 2'(k)}] = 1'b1;
			end
		end
	endtask

	function automatic word_t model_read(input addr_t a, input logic be);
		if (be) return {24'h000000, shadow[a[10:0]]}; // Zero-extended byte
		return {shadow[{a[10:2], 2'd3}], shadow[{a[10:2], 2'd2}],
			shadow[{a[10:2], 2'd1}], shadow[{a[10:2], 2'd0}]};
	endfunction

	function automatic logic word_written(input addr_t a);
		return written[{a[10:2], 2'd0}] && written[{a[10:2], 2'd1}]
			&& written[{a[10:2], 2'd2}] && written[{a[10:2], 2'd3}];
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	////////////////////////////////////////
	// Four-phase requester
	////////////////////////////////////////
	task automatic handshake(input addr_t a, input logic we, input logic be, input word_t wdata,
			input int hold, output word_t rdata);
		int cycles;
		int i;
		rdata = '0;
		@(posedge clk);
		req <= 1'b1;
		addr <= a;
		write_enable <= we;
		byte_enable <= be;
		data_in <= wdata;
		cycles = 0;
		while (!ack && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (!ack) begin
			$display("Timeout: ack never rose for address 0x%h", a);
			errors++;
			aborted = 1'b1;
			req <= 1'b0;
			return;
		end
		rdata = data_out; // Valid together with ack
		for (i = 0; i < hold; i++) begin
			@(posedge clk);
			check_value("ack", word_t'(ack), 32'h1); // Must hold while req stays high
		end
		req <= 1'b0;
		cycles = 0;
		while (ack && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (ack) begin
			$display("Timeout: ack stayed high after req fell for address 0x%h", a);
			errors++;
			aborted = 1'b1;
		end
	endtask

	// One access checked against the shadow
	task automatic transfer(input addr_t a, input logic we, input logic be, input word_t wdata,
			input int hold);
		word_t got;
		word_t exp;
		if (aborted) return;
		if (we) write_shadow(a, be, wdata);
		exp = model_read(a, be);
		handshake(a, we, be, wdata, hold, got);
		if (!aborted) check_value($sformatf("data_out at 0x%h", a), got, exp);
	endtask

	task automatic end_test(input int num, input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("Test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: %0d errors", num, name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		logic [31:0] r;
		word_t d;
		addr_t a;
		logic be;
		int pick;
		int i;
		reset <= 1'b1;
		req <= 1'b0;
		addr <= '0;
		write_enable <= 1'b0;
		byte_enable <= 1'b0;
		data_in <= '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		@(posedge clk);
		check_value("ack", word_t'(ack), 32'h0);
		transfer(16'h0010, 1'b1, 1'b0, 32'hdeadbeef, 0);
		transfer(16'h0010, 1'b0, 1'b0, 32'h0, 0);
		end_test(1, "word write and read back");

		transfer(16'h0048, 1'b1, 1'b0, 32'h11223344, 0);
		transfer(16'h0049, 1'b1, 1'b1, 32'h000000aa, 0);
		transfer(16'h004b, 1'b1, 1'b1, 32'h000000bb, 0);
		transfer(16'h0048, 1'b0, 1'b0, 32'h0, 0); // Merged word
		transfer(16'h0049, 1'b0, 1'b1, 32'h0, 0);
		transfer(16'h004a, 1'b0, 1'b1, 32'h0, 0);
		end_test(2, "byte merge");

		// 32-byte stride keeps every address on index 0
		for (i = 0; i < 5; i++) transfer(addr_t'(16'h0100 + i * 32 + 4), 1'b1, 1'b0,
			word_t'(32'hc0de0000 + i), 0);
		for (i = 0; i < 5; i++) transfer(addr_t'(16'h0100 + i * 32 + 4), 1'b0, 1'b0, 32'h0, 0);
		end_test(3, "dirty eviction and refill");

		for (i = 0; i < 300; i++) begin
			r = $random(seed);
			a = addr_t'(r[10:0]);
			be = r[11];
			if (r[12] && wr_list.size() > 0) begin
				pick = int'(r[31:16]) % wr_list.size();
				a = wr_list[pick];
				if (!word_written(a)) be = 1'b1; // Only the byte itself is known
				transfer(a, 1'b0, be, 32'h0, 0);
			end else begin
				d = $random(seed);
				transfer(a, 1'b1, be, d, 0);
				wr_list.push_back(a);
			end
		end
		end_test(4, "random operations");

		transfer(16'h0200, 1'b1, 1'b0, 32'h5a5a1234, 6);
		transfer(16'h0200, 1'b0, 1'b0, 32'h0, 6);
		end_test(5, "held request");

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && !aborted)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
	input logic clk,
	input logic reset,
	input logic req,
	output logic ack,
	input cache_pkg::addr_t addr,
	input logic write_enable,
	input logic byte_enable,
	input cache_pkg::word_t data_in,
	output cache_pkg::word_t data_out
);
	import cache_pkg::*;

	// Port stage to cache
	logic cache_enable;
	addr_t cache_addr;
	logic cache_write_enable;
	logic cache_byte_enable;
	word_t cache_data_in;
	logic cache_hit;
	word_t cache_data_out;

	////////////////////////////////////////
	// Cache to sequencer
	////////////////////////////////////////
	logic mem_write_req;
	addr_t mem_write_addr;
	line_t mem_write_data;
	logic mem_write_ack;
	logic mem_read_req;
	addr_t mem_read_addr;
	line_t mem_read_data;
	logic mem_read_ack;

	// Single memory port
	logic mem_req;
	logic mem_we;
	addr_t mem_addr;
	line_t mem_wdata;
	line_t mem_rdata;
	logic mem_ack;

	cpu_port i_cpu_port (
		.clk(clk), .reset(reset),
		.req(req), .ack(ack), .addr(addr), .write_enable(write_enable),
		.byte_enable(byte_enable), .data_in(data_in), .data_out(data_out),
		.cache_enable(cache_enable), .cache_addr(cache_addr),
		.cache_write_enable(cache_write_enable), .cache_byte_enable(cache_byte_enable),
		.cache_data_in(cache_data_in), .cache_hit(cache_hit),
		.cache_data_out(cache_data_out)
	);

	cache_direct i_cache_direct (
		.clk(clk), .reset(reset),
		.enable(cache_enable), .addr(cache_addr), .write_enable(cache_write_enable),
		.byte_enable(cache_byte_enable), .data_in(cache_data_in),
		.data_out(cache_data_out), .hit(cache_hit),
		.mem_write_req(mem_write_req), .mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data), .mem_write_ack(mem_write_ack),
		.mem_read_req(mem_read_req), .mem_read_addr(mem_read_addr),
		.mem_read_data(mem_read_data), .mem_read_ack(mem_read_ack)
	);

	mem_sequencer i_mem_sequencer (
		.clk(clk), .reset(reset),
		.mem_write_req(mem_write_req), .mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data), .mem_write_ack(mem_write_ack),
		.mem_read_req(mem_read_req), .mem_read_addr(mem_read_addr),
		.mem_read_data(mem_read_data), .mem_read_ack(mem_read_ack),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack)
	);

	main_memory i_main_memory (
		.clk(clk), .reset(reset),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack)
	);

endmodule

// ==== verilog/main_memory.sv ====
`timescale 1ns/1ps

`include "cache_consts.svh"

module main_memory #(
	parameter int LATENCY = `MEM_LATENCY
) (
	input logic clk,
	input logic reset,
	input logic mem_req,
	input logic mem_we,
	input cache_pkg::addr_t mem_addr,
	input cache_pkg::line_t mem_wdata,
	output cache_pkg::line_t mem_rdata,
	output logic mem_ack
);
	import cache_pkg::*;

	localparam int OB = $bits(offset_t);
	localparam int LB = $clog2(`MEM_LINES); // Higher address bits wrap
	localparam int CW = (LATENCY > 1) ? $clog2(LATENCY) : 1;

	line_t mem [`MEM_LINES];

	logic [LB-1:0] line_addr;
	assign line_addr = mem_addr[OB +: LB];

	logic busy;
	logic [CW-1:0] count; // Cycles left minus one

	////////////////////////////////////////
	// Latency counter and handshake
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
			mem_ack <= 1'b0;
		end else if (busy) begin
			if (count == '0) begin
				busy <= 1'b0;
				mem_ack <= 1'b1;
			end else begin
				count <= count - 1'b1;
			end
		end else if (mem_ack) begin
			if (!mem_req) mem_ack <= 1'b0; // Release phase
		end else if (mem_req) begin
			busy <= 1'b1;
			count <= CW'(LATENCY - 1);
		end
	end

	// Access happens on the ack edge
	always_ff @(posedge clk) begin
		if (busy && count == '0) begin
			if (mem_we) mem[line_addr] <= mem_wdata;
			else mem_rdata <= mem[line_addr];
		end
	end

endmodule

// ==== verilog/mem_sequencer.sv ====
`timescale 1ns/1ps

module mem_sequencer (
	input logic clk,
	input logic reset,
	// Write-back from the cache
	input logic mem_write_req,
	input cache_pkg::addr_t mem_write_addr,
	input cache_pkg::line_t mem_write_data,
	output logic mem_write_ack,
	// Fill to the cache
	input logic mem_read_req,
	input cache_pkg::addr_t mem_read_addr,
	output cache_pkg::line_t mem_read_data,
	output logic mem_read_ack,
	// Backing memory port
	output logic mem_req,
	output logic mem_we,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::line_t mem_wdata,
	input cache_pkg::line_t mem_rdata,
	input logic mem_ack
);
	import cache_pkg::*;

	seq_state_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SEQ_IDLE;
			mem_req <= 1'b0;
			mem_write_ack <= 1'b0;
			mem_read_ack <= 1'b0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (mem_write_req) begin // Dirty victim first
						mem_req <= 1'b1;
						state <= WRITE;
					end else if (mem_read_req) begin
						mem_req <= 1'b1;
						state <= READ;
					end
				end
				WRITE: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
						mem_write_ack <= 1'b1;
						state <= WRITE_REL;
					end
				end
				// Both sides must release before the port is reused
				WRITE_REL: begin
					if (!mem_write_req && !mem_ack) begin
						mem_write_ack <= 1'b0;
						state <= SEQ_IDLE;
					end
				end
				READ: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
						mem_read_ack <= 1'b1;
						state <= READ_REL;
					end
				end
				READ_REL: begin
					if (!mem_read_req && !mem_ack) begin
						mem_read_ack <= 1'b0;
						state <= SEQ_IDLE;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// Transfer payload, read data held for the fill ack
	always_ff @(posedge clk) begin
		if (state == SEQ_IDLE) begin
			mem_we <= mem_write_req;
			mem_addr <= mem_write_req ? mem_write_addr : mem_read_addr;
			mem_wdata <= mem_write_data;
		end
		if (state == READ && mem_ack) mem_read_data <= mem_rdata;
	end

endmodule

// ==== verilog/cache_direct.sv ====
`timescale 1ns/1ps

`include "cache_consts.svh"

module cache_direct #(
	parameter int DEPTH = `CACHE_DEPTH
) (
	input logic clk,
	input logic reset,
	// Requester side
	input logic enable,
	input cache_pkg::addr_t addr,
	input logic write_enable,
	input logic byte_enable,
	input cache_pkg::word_t data_in,
	output cache_pkg::word_t data_out,
	output logic hit,
	// Write-back side
	output logic mem_write_req,
	output cache_pkg::addr_t mem_write_addr,
	output cache_pkg::line_t mem_write_data,
	input logic mem_write_ack,
	// Fill side
	output logic mem_read_req,
	output cache_pkg::addr_t mem_read_addr,
	input cache_pkg::line_t mem_read_data,
	input logic mem_read_ack
);
	import cache_pkg::*;

	localparam int OB = $bits(offset_t);
	localparam int IB = $clog2(DEPTH);
	localparam int SHIFT = OB + IB; // Tag starts here

	////////////////////////////////////////
	// Address split
	////////////////////////////////////////
	offset_t offset;
	logic [IB-1:0] index;
	tag_t tag;

	assign offset = addr[OB-1:0];
	assign index = addr[SHIFT-1:OB];
	assign tag = tag_t'(addr >> SHIFT); // Zero-extended for deeper caches

	// Fill target comes from the pending read address
	logic [IB-1:0] fill_index;
	tag_t fill_tag;

	assign fill_index = mem_read_addr[SHIFT-1:OB];
	assign fill_tag = tag_t'(mem_read_addr >> SHIFT);

	////////////////////////////////////////
	// Line storage
	////////////////////////////////////////
	logic [DEPTH-1:0] valid;
	logic [DEPTH-1:0] dirty;
	tag_t tags [DEPTH];
	line_t lines [DEPTH];

	line_t line_out;
	word_t word_out;
	byte_t byte_out;
	logic hit_int;

	assign line_out = lines[index];
	assign word_out = line_out[offset[OB-1:2] * 32 +: 32]; // Low two bits ignored
	assign byte_out = line_out[offset * 8 +: 8];

	assign hit_int = valid[index] && (tags[index] == tag);
	assign hit = enable & hit_int;

	// Read data follows the address, so a write shows up the next cycle
	assign data_out = byte_enable ? {24'h000000, byte_out} : word_out;

	// No new miss while a transfer is still in flight
	logic mem_busy;
	assign mem_busy = mem_write_req | mem_read_req | mem_write_ack | mem_read_ack;

	////////////////////////////////////////
	// Control arrays and memory requests
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
			mem_write_req <= 1'b0;
			mem_read_req <= 1'b0;
		end else begin
			if (mem_write_ack) mem_write_req <= 1'b0;

			if (mem_read_ack && mem_read_req) begin
				valid[fill_index] <= 1'b1; // Fresh line is clean
				dirty[fill_index] <= 1'b0;
				mem_read_req <= 1'b0;
			end

			if (enable) begin
				if (hit_int) begin
					if (write_enable) dirty[index] <= 1'b1;
				end else if (!mem_busy) begin
					if (valid[index] && dirty[index]) mem_write_req <= 1'b1;
					valid[index] <= 1'b0;
					mem_read_req <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// Line data, tags and request payload
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (mem_read_ack && mem_read_req) begin
			lines[fill_index] <= mem_read_data;
			tags[fill_index] <= fill_tag;
		end

		if (enable && hit_int && write_enable) begin
			if (byte_enable) begin
				lines[index][offset * 8 +: 8] <= data_in[7:0];
			end else begin
				lines[index][offset[OB-1:2] * 32 +: 32] <= data_in;
			end
		end

		if (enable && !hit_int && !mem_busy) begin
			// Victim goes back to its own line address
			mem_write_addr <= (addr_t'(tags[index]) << SHIFT) | (addr_t'(index) << OB);
			mem_write_data <= lines[index];
			mem_read_addr <= (addr >> OB) << OB; // Line aligned
		end
	end

endmodule

// ==== verilog/cpu_port.sv ====
`timescale 1ns/1ps

module cpu_port (
	input logic clk,
	input logic reset,
	// Requester side
	input logic req,
	output logic ack,
	input cache_pkg::addr_t addr,
	input logic write_enable,
	input logic byte_enable,
	input cache_pkg::word_t data_in,
	output cache_pkg::word_t data_out,
	// Cache side
	output logic cache_enable,
	output cache_pkg::addr_t cache_addr,
	output logic cache_write_enable,
	output logic cache_byte_enable,
	output cache_pkg::word_t cache_data_in,
	input logic cache_hit,
	input cache_pkg::word_t cache_data_out
);
	import cache_pkg::*;

	port_state_t state;

	// Request held for the whole transaction
	addr_t addr_q;
	logic write_q;
	logic byte_q;
	word_t data_q;

	assign cache_enable = (state == BUSY); // Held until the hit
	assign cache_addr = addr_q;
	assign cache_byte_enable = byte_q;
	assign cache_data_in = data_q;

	// Write lands on the hit cycle only
	assign cache_write_enable = cache_enable & write_q & cache_hit;

	////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			ack <= 1'b0;
		end else begin
			case (state)
				IDLE: if (req) state <= BUSY;
				BUSY: if (cache_hit) state <= DONE; // Misses just keep waiting
				DONE: begin
					if (!ack) begin
						ack <= 1'b1;
					end else if (!req) begin
						ack <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Latch the request, then the result one cycle after the hit
	always_ff @(posedge clk) begin
		if (state == IDLE && req) begin
			addr_q <= addr;
			write_q <= write_enable;
			byte_q <= byte_enable;
			data_q <= data_in;
		end
		if (state == DONE && !ack) data_out <= cache_data_out; // Includes a just-written value
	end

endmodule

// ==== verilog/cache_pkg.sv ====
`include "cache_consts.svh"

package cache_pkg;

	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [`LINE_WIDTH-1:0] line_t;

	// Address = tag | index | offset
	typedef logic [$clog2(`LINE_WIDTH / 8)-1:0] offset_t;
	typedef logic [$clog2(`CACHE_DEPTH)-1:0] index_t;
	typedef logic [`ADDR_WIDTH-$bits(offset_t)-$bits(index_t)-1:0] tag_t;

	// Requester handshake
	typedef enum logic [1:0] {IDLE, BUSY, DONE} port_state_t;

	// Memory sequencer, write-back always ahead of fill
	typedef enum logic [2:0] {
		SEQ_IDLE,
		WRITE,
		WRITE_REL,
		READ,
		READ_REL
	} seq_state_t;

endpackage

// ==== include/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

////////////////////////////////////////
// Requester side
////////////////////////////////////////

`define ADDR_WIDTH 16 // Byte address bits

////////////////////////////////////////
// Cache and backing memory geometry
////////////////////////////////////////

`define LINE_WIDTH 64 // Bits per cache line and per memory word
`define CACHE_DEPTH 4 // Cache lines

// 256 lines of 8 bytes cover byte addresses 0 to 2047
`define MEM_LINES 256
`define MEM_LATENCY 3 // Cycles from request to ack

`endif
